/* design/lsu_pkg.sv */
// LSU package: data widths, address map, opcode and trap enums, request and response bundles
package lsu_pkg;

  parameter int XLEN = 32, BYTE_WIDTH = 8;

  parameter logic [XLEN-1:0] IMEM_MEM_START  = 32'h0000_0000, IMEM_MEM_END  = 32'h0000_0FFF;
  parameter logic [XLEN-1:0] CLINT_MEM_START = 32'h0200_0000, CLINT_MEM_END = 32'h0200_000F;
  parameter logic [XLEN-1:0] UART_MEM_START  = 32'h1000_0000, UART_MEM_END  = 32'h1000_0007;
  parameter logic [XLEN-1:0] DATA_MEM_START  = 32'h8000_0000, DATA_MEM_END  = 32'h8000_03FF;

  typedef enum logic [3:0] {
    LSU_NONE,
    LSU_LOAD_B,
    LSU_LOAD_H,
    LSU_LOAD_W,
    LSU_LOAD_BU,
    LSU_LOAD_HU,
    LSU_STORE_B,
    LSU_STORE_H,
    LSU_STORE_W
  } lsu_ls_t;

  typedef enum logic [2:0] {
    IMEM,
    CLINT,
    UART,
    DMEM,
    UNKNOWN
  } lsu_mem_src_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_mode_t;

  typedef enum logic [3:0] {
    CAUSE_NONE             = 4'd0,
    CAUSE_ILLEGAL          = 4'd2,
    CAUSE_LOAD_MISALIGNED  = 4'd4,
    CAUSE_LOAD_FAULT       = 4'd5,
    CAUSE_STORE_MISALIGNED = 4'd6,
    CAUSE_STORE_FAULT      = 4'd7
  } trap_cause_t;

  typedef struct packed {
    logic            valid;
    logic            is_store;
    logic [2:0]      funct3;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    priv_mode_t      priv;
  } lsu_req_t;

  typedef struct packed {
    logic load_misaligned;
    logic load_fault;
    logic store_misaligned;
    logic store_fault;
  } lsu_traps_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
    logic            trap;
    trap_cause_t     cause;
  } lsu_resp_t;

endpackage

/* design/lsu_decode.sv */
// LSU decode: maps RV32I load/store funct3 onto the LSU opcode and flags reserved encodings
`timescale 1ns/100ps

module lsu_decode (
  input  logic              i_valid,
  input  logic              i_is_store,
  input  logic [2:0]        i_funct3,
  output lsu_pkg::lsu_ls_t  o_op,
  output logic              o_illegal
);

  import lsu_pkg::*;

  lsu_ls_t op_dec;
  logic    reserved;

  always_comb begin
    op_dec   = LSU_NONE;
    reserved = 1'b0;
    if (i_is_store) begin
      case (i_funct3)
        3'b000:  op_dec = LSU_STORE_B;
        3'b001:  op_dec = LSU_STORE_H;
        3'b010:  op_dec = LSU_STORE_W;
        default: reserved = 1'b1;
      endcase
    end else begin
      case (i_funct3)
        3'b000:  op_dec = LSU_LOAD_B;
        3'b001:  op_dec = LSU_LOAD_H;
        3'b010:  op_dec = LSU_LOAD_W;
        3'b100:  op_dec = LSU_LOAD_BU;
        3'b101:  op_dec = LSU_LOAD_HU;
        default: reserved = 1'b1;  // Funct3 3, 6 and 7 have no load
      endcase
    end
  end

  // A reserved encoding leaves op_dec at LSU_NONE
  assign o_op      = i_valid ? op_dec : LSU_NONE;
  assign o_illegal = i_valid && reserved;

endmodule

/* design/lsu.sv */
// Load-store unit: region decode, store shaping, load extension and trap detection
`timescale 1ns/100ps

module lsu (
  input  lsu_pkg::lsu_ls_t          i_op,
  input  logic [lsu_pkg::XLEN-1:0]  i_addr,
  input  logic [lsu_pkg::XLEN-1:0]  i_wdata,
  input  logic [lsu_pkg::XLEN-1:0]  i_rdata_imem,
  input  logic [lsu_pkg::XLEN-1:0]  i_rdata_clint,
  input  logic [lsu_pkg::XLEN-1:0]  i_rdata_uart,
  input  logic [lsu_pkg::XLEN-1:0]  i_rdata_dmem,
  input  lsu_pkg::priv_mode_t       i_priv_mode,
  input  logic                      i_trap_req,
  output logic [lsu_pkg::XLEN-1:0]  o_addr,
  output logic [lsu_pkg::XLEN-1:0]  o_wdata,
  output logic [lsu_pkg::XLEN-1:0]  o_rdata,
  output logic [3:0]                o_wstrb,
  output logic                      o_re_uart,
  output logic                      o_we_dmem,
  output logic                      o_we_uart,
  output logic                      o_we_clint,
  output lsu_pkg::lsu_traps_t       o_traps
);

  import lsu_pkg::*;

  localparam int HALF_WIDTH = 2 * BYTE_WIDTH;

  lsu_mem_src_t    mem_src;
  logic [XLEN-1:0] mem_rdata;
  logic            is_load;
  logic            is_store;
  logic            load_ok;
  logic            store_ok;
  logic            misaligned;

  function automatic logic in_region(input logic [XLEN-1:0] addr,
                                     input logic [XLEN-1:0] lo,
                                     input logic [XLEN-1:0] hi);
    return (addr >= lo) && (addr <= hi);
  endfunction

  assign is_load  = i_op inside {LSU_LOAD_B, LSU_LOAD_H, LSU_LOAD_W, LSU_LOAD_BU, LSU_LOAD_HU};
  assign is_store = i_op inside {LSU_STORE_B, LSU_STORE_H, LSU_STORE_W};

  // First matching region wins
  always_comb begin
    if (in_region(i_addr, IMEM_MEM_START, IMEM_MEM_END)) begin
      mem_src = IMEM;
      o_addr  = i_addr - IMEM_MEM_START;
    end else if (in_region(i_addr, CLINT_MEM_START, CLINT_MEM_END)) begin
      mem_src = CLINT;
      o_addr  = i_addr - CLINT_MEM_START;
    end else if (in_region(i_addr, UART_MEM_START, UART_MEM_END)) begin
      mem_src = UART;
      o_addr  = i_addr - UART_MEM_START;
    end else if (in_region(i_addr, DATA_MEM_START, DATA_MEM_END)) begin
      mem_src = DMEM;
      o_addr  = i_addr - DATA_MEM_START;
    end else begin
      mem_src = UNKNOWN;
      o_addr  = '0;
    end
  end

  always_comb begin
    case (mem_src)
      IMEM:    mem_rdata = i_rdata_imem;
      CLINT:   mem_rdata = i_rdata_clint;
      UART:    mem_rdata = i_rdata_uart;
      DMEM:    mem_rdata = i_rdata_dmem;
      default: mem_rdata = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      LSU_LOAD_B: begin
        o_rdata = {{(XLEN-BYTE_WIDTH){mem_rdata[BYTE_WIDTH-1]}}, mem_rdata[BYTE_WIDTH-1:0]};
      end
      LSU_LOAD_H: begin
        o_rdata = {{(XLEN-HALF_WIDTH){mem_rdata[HALF_WIDTH-1]}}, mem_rdata[HALF_WIDTH-1:0]};
      end
      LSU_LOAD_BU: o_rdata = {{(XLEN-BYTE_WIDTH){1'b0}}, mem_rdata[BYTE_WIDTH-1:0]};
      LSU_LOAD_HU: o_rdata = {{(XLEN-HALF_WIDTH){1'b0}}, mem_rdata[HALF_WIDTH-1:0]};
      default:     o_rdata = mem_rdata;
    endcase
  end

  // Store data and strobes sit in the low lanes, the target aligns them
  always_comb begin
    o_wdata = i_wdata;
    o_wstrb = 4'b0000;
    case (i_op)
      LSU_STORE_B: begin
        o_wdata = {{(XLEN-BYTE_WIDTH){1'b0}}, i_wdata[BYTE_WIDTH-1:0]};
        o_wstrb = 4'b0001;
      end
      LSU_STORE_H: begin
        o_wdata = {{(XLEN-HALF_WIDTH){1'b0}}, i_wdata[HALF_WIDTH-1:0]};
        o_wstrb = 4'b0011;
      end
      LSU_STORE_W: o_wstrb = 4'b1111;
      default: begin
      end
    endcase
  end

  assign o_re_uart  = is_load && !i_trap_req && (mem_src == UART);  // Read clears RX full
  assign o_we_dmem  = is_store && !i_trap_req && (mem_src == DMEM);
  assign o_we_uart  = is_store && !i_trap_req && (mem_src == UART);
  assign o_we_clint = is_store && !i_trap_req && (mem_src == CLINT);

  always_comb begin
    load_ok  = 1'b0;
    store_ok = 1'b0;
    case (i_priv_mode)
      PRIV_M: begin
        load_ok  = mem_src inside {IMEM, CLINT, UART, DMEM};
        store_ok = mem_src inside {CLINT, UART, DMEM};
      end
      PRIV_U: begin
        load_ok  = mem_src inside {IMEM, DMEM};
        store_ok = mem_src == DMEM;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (i_op)
      LSU_LOAD_H, LSU_LOAD_HU, LSU_STORE_H: misaligned = i_addr[0];
      LSU_LOAD_W, LSU_STORE_W:              misaligned = |i_addr[1:0];
      default:                              misaligned = 1'b0;
    endcase
    o_traps.load_misaligned  = is_load && misaligned;
    o_traps.load_fault       = is_load && !load_ok;
    o_traps.store_misaligned = is_store && misaligned;
    o_traps.store_fault      = is_store && !store_ok;
  end

endmodule

/* design/data_mem.sv */
// Data memory: byte-lane RAM with strobed writes and an unaligned word read
`timescale 1ns/100ps

module data_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_we,
  input  logic [lsu_pkg::XLEN-1:0]  i_addr,
  input  logic [lsu_pkg::XLEN-1:0]  i_wdata,
  input  logic [3:0]                i_wstrb,
  output logic [lsu_pkg::XLEN-1:0]  o_rdata
);

  import lsu_pkg::*;

  localparam int NUM_BYTES = DMEM_WORDS * 4;
  localparam int AW        = $clog2(NUM_BYTES);

  logic [BYTE_WIDTH-1:0] mem [NUM_BYTES];
  logic [AW-3:0]         word_idx;
  logic [1:0]            offs;
  logic [3:0]            lane_strb;
  logic [XLEN-1:0]       lane_data;
  logic [XLEN-1:0]       word;

  assign word_idx  = i_addr[AW-1:2];  // Offsets past the RAM size wrap
  assign offs      = i_addr[1:0];
  assign lane_strb = i_wstrb << offs;
  assign lane_data = i_wdata << {offs, 3'b000};

  always_ff @(posedge i_clk) begin
    if (i_rst_n && i_we) begin
      for (int k = 0; k < 4; k++) begin
        if (lane_strb[k]) begin
          mem[{word_idx, 2'(k)}] <= lane_data[BYTE_WIDTH*k +: BYTE_WIDTH];
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      word[BYTE_WIDTH*k +: BYTE_WIDTH] = mem[{word_idx, 2'(k)}];
    end
  end

  assign o_rdata = word >> {offs, 3'b000};  // Upper bytes read as zero

endmodule

/* design/clint.sv */
// CLINT: free-running mtime, mtimecmp compare register and registered timer interrupt
`timescale 1ns/100ps

module clint (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_we,
  input  logic [lsu_pkg::XLEN-1:0]  i_addr,
  input  logic [lsu_pkg::XLEN-1:0]  i_wdata,
  input  logic [3:0]                i_wstrb,
  output logic [lsu_pkg::XLEN-1:0]  o_rdata,
  output logic                      o_timer_irq
);

  import lsu_pkg::*;

  logic [63:0]     mtime;
  logic [63:0]     mtimecmp;
  logic [1:0]      word_sel;
  logic [3:0]      lane_strb;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] cur_word;
  logic [XLEN-1:0] new_word;

  assign word_sel  = i_addr[3:2];  // 0/1 mtime, 2/3 mtimecmp
  assign lane_strb = i_wstrb << i_addr[1:0];
  assign lane_data = i_wdata << {i_addr[1:0], 3'b000};

  always_comb begin
    case (word_sel)
      2'd0:    cur_word = mtime[31:0];
      2'd1:    cur_word = mtime[63:32];
      2'd2:    cur_word = mtimecmp[31:0];
      default: cur_word = mtimecmp[63:32];
    endcase
    for (int k = 0; k < 4; k++) begin
      new_word[BYTE_WIDTH*k +: BYTE_WIDTH] = lane_strb[k] ? lane_data[BYTE_WIDTH*k +: BYTE_WIDTH]
                                                          : cur_word[BYTE_WIDTH*k +: BYTE_WIDTH];
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mtime       <= '0;
      mtimecmp    <= '1;
      o_timer_irq <= 1'b0;
    end else begin
      if (i_we && !word_sel[1]) begin
        mtime <= word_sel[0] ? {new_word, mtime[31:0]} : {mtime[63:32], new_word};
      end else begin
        mtime <= mtime + 64'd1;
      end
      if (i_we && word_sel[1]) begin
        mtimecmp <= word_sel[0] ? {new_word, mtimecmp[31:0]} : {mtimecmp[63:32], new_word};
      end
      o_timer_irq <= mtime >= mtimecmp;
    end
  end

  assign o_rdata = cur_word >> {i_addr[1:0], 3'b000};

endmodule

/* design/uart_regs.sv */
// UART registers: transmit-byte strobe, receive holding register and receive status
`timescale 1ns/100ps

module uart_regs (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_we,
  input  logic                      i_re,
  input  logic [lsu_pkg::XLEN-1:0]  i_addr,
  input  logic [lsu_pkg::XLEN-1:0]  i_wdata,
  input  logic                      i_rx_valid,
  input  logic [7:0]                i_rx_data,
  output logic [lsu_pkg::XLEN-1:0]  o_rdata,
  output logic                      o_tx_valid,
  output logic [7:0]                o_tx_data
);

  logic [7:0] rx_data;
  logic       rx_full;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_tx_valid <= 1'b0;
      o_tx_data  <= '0;
      rx_data    <= '0;
      rx_full    <= 1'b0;
    end else begin
      o_tx_valid <= i_we && !i_addr[2];  // Single-cycle pulse per byte store
      if (i_we && !i_addr[2]) begin
        o_tx_data <= i_wdata[7:0];
      end
      if (i_rx_valid) begin
        rx_data <= i_rx_data;
        rx_full <= 1'b1;
      end else if (i_re && i_addr[2]) begin
        rx_full <= 1'b0;
      end
    end
  end

  assign o_rdata = i_addr[2] ? {23'd0, rx_full, rx_data} : {24'd0, o_tx_data};

endmodule

/* design/lsu_result.sv */
// LSU result: encodes the trap cause by priority and registers the response
`timescale 1ns/100ps

module lsu_result (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  logic                      i_illegal,
  input  lsu_pkg::lsu_traps_t       i_traps,
  input  logic [lsu_pkg::XLEN-1:0]  i_rdata,
  output logic                      o_trap_req,
  output lsu_pkg::lsu_resp_t        o_resp
);

  import lsu_pkg::*;

  trap_cause_t cause;

  // Illegal first, then misaligned, then access fault
  always_comb begin
    if (i_illegal) begin
      cause = CAUSE_ILLEGAL;
    end else if (i_traps.load_misaligned) begin
      cause = CAUSE_LOAD_MISALIGNED;
    end else if (i_traps.store_misaligned) begin
      cause = CAUSE_STORE_MISALIGNED;
    end else if (i_traps.load_fault) begin
      cause = CAUSE_LOAD_FAULT;
    end else if (i_traps.store_fault) begin
      cause = CAUSE_STORE_FAULT;
    end else begin
      cause = CAUSE_NONE;
    end
  end

  assign o_trap_req = |i_traps;  // Blocks the write enables in the LSU

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_resp.valid <= 1'b0;
      o_resp.trap  <= 1'b0;
      o_resp.cause <= CAUSE_NONE;
    end else begin
      o_resp.valid <= i_valid;
      o_resp.trap  <= i_valid && (cause != CAUSE_NONE);
      o_resp.cause <= i_valid ? cause : CAUSE_NONE;
    end
  end

  always_ff @(posedge i_clk) begin
    o_resp.rdata <= (cause != CAUSE_NONE) ? '0 : i_rdata;
  end

endmodule

/* design/mem_subsys_top.sv */
// Memory-access subsystem: decode, LSU, result stage, data memory, CLINT and UART
`timescale 1ns/100ps

module mem_subsys_top #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  lsu_pkg::lsu_req_t         i_req,
  input  logic [lsu_pkg::XLEN-1:0]  i_imem_rdata,
  output logic [lsu_pkg::XLEN-1:0]  o_imem_addr,
  output lsu_pkg::lsu_resp_t        o_resp,
  input  logic                      i_uart_rx_valid,
  input  logic [7:0]                i_uart_rx_data,
  output logic                      o_uart_tx_valid,
  output logic [7:0]                o_uart_tx_data,
  output logic                      o_timer_irq
);

  import lsu_pkg::*;

  lsu_ls_t         op;
  logic            illegal;
  lsu_traps_t      traps;
  logic            trap_req;
  logic [XLEN-1:0] periph_addr;
  logic [XLEN-1:0] periph_wdata;
  logic [3:0]      periph_wstrb;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] rdata_clint;
  logic [XLEN-1:0] rdata_uart;
  logic [XLEN-1:0] rdata_dmem;
  logic            re_uart;
  logic            we_dmem;
  logic            we_uart;
  logic            we_clint;

  assign o_imem_addr = periph_addr;  // IMEM base is zero so the offset is the byte address

  lsu_decode decode_i (
    .i_valid(i_req.valid), .i_is_store(i_req.is_store), .i_funct3(i_req.funct3),
    .o_op(op), .o_illegal(illegal)
  );

  lsu lsu_i (
    .i_op(op), .i_addr(i_req.addr), .i_wdata(i_req.wdata),
    .i_rdata_imem(i_imem_rdata), .i_rdata_clint(rdata_clint),
    .i_rdata_uart(rdata_uart), .i_rdata_dmem(rdata_dmem),
    .i_priv_mode(i_req.priv), .i_trap_req(trap_req),
    .o_addr(periph_addr), .o_wdata(periph_wdata), .o_rdata(load_data), .o_wstrb(periph_wstrb),
    .o_re_uart(re_uart), .o_we_dmem(we_dmem), .o_we_uart(we_uart), .o_we_clint(we_clint),
    .o_traps(traps)
  );

  lsu_result result_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_req.valid), .i_illegal(illegal),
    .i_traps(traps), .i_rdata(load_data), .o_trap_req(trap_req), .o_resp(o_resp)
  );

  data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(we_dmem), .i_addr(periph_addr),
    .i_wdata(periph_wdata), .i_wstrb(periph_wstrb), .o_rdata(rdata_dmem)
  );

  clint clint_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(we_clint), .i_addr(periph_addr),
    .i_wdata(periph_wdata), .i_wstrb(periph_wstrb), .o_rdata(rdata_clint),
    .o_timer_irq(o_timer_irq)
  );

  uart_regs uart_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(we_uart), .i_re(re_uart), .i_addr(periph_addr),
    .i_wdata(periph_wdata), .i_rx_valid(i_uart_rx_valid), .i_rx_data(i_uart_rx_data),
    .o_rdata(rdata_uart), .o_tx_valid(o_uart_tx_valid), .o_tx_data(o_uart_tx_data)
  );

endmodule

/* tb/tb_mem_subsys.sv */
// Self-checking memory subsystem testbench driven by a table of requests and expected responses
`timescale 1ns/100ps

module tb_mem_subsys;

  import lsu_pkg::*;

  typedef struct packed {
    lsu_req_t    req;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        exp_valid;
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    trap_cause_t exp_cause;
    logic        exp_tx_valid;
    logic [7:0]  exp_tx_data;
    logic        exp_irq;
  } test_entry_t;

  localparam logic [31:0] IMEM_XOR = 32'hA5A5_0000;

  logic            clk;
  logic            rst_n;
  lsu_req_t        req;
  logic [XLEN-1:0] imem_rdata;
  logic [XLEN-1:0] imem_addr;
  lsu_resp_t       resp;
  logic            rx_valid;
  logic [7:0]      rx_data;
  logic            tx_valid;
  logic [7:0]      tx_data;
  logic            timer_irq;

  test_entry_t tests[$];
  string       names[$];
  logic [7:0]  ref_mem [1024];  // Expected DMEM bytes
  logic        cur_irq;
  int          seed = 32'hb178_5994;
  int          cycle_count = 0;
  int          max_cycles = 0;
  int          passed = 0;
  int          failed = 0;

  mem_subsys_top #(.DMEM_WORDS(256)) dut_i (
    .i_clk(clk), .i_rst_n(rst_n), .i_req(req), .i_imem_rdata(imem_rdata),
    .o_imem_addr(imem_addr), .o_resp(resp), .i_uart_rx_valid(rx_valid),
    .i_uart_rx_data(rx_data), .o_uart_tx_valid(tx_valid), .o_uart_tx_data(tx_data),
    .o_timer_irq(timer_irq)
  );

  assign imem_rdata = imem_addr ^ IMEM_XOR;  // Instruction memory model

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (max_cycles > 0);
    wait (cycle_count >= max_cycles);
    $display("Timeout: no final result after %0d cycles", max_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic test_entry_t make_req(input logic st, input logic [2:0] f3,
                                           input logic [31:0] addr, input logic [31:0] wdata,
                                           input priv_mode_t priv);
    test_entry_t e;
    e = '0;
    e.req.valid    = 1'b1;
    e.req.is_store = st;
    e.req.funct3   = f3;
    e.req.addr     = addr;
    e.req.wdata    = wdata;
    e.req.priv     = priv;
    e.exp_valid    = 1'b1;
    e.exp_cause    = CAUSE_NONE;
    e.exp_irq      = cur_irq;
    return e;
  endfunction

  // Little-endian RV32I load rule applied to the expected byte array
  function automatic logic [31:0] ref_load(input logic [9:0] a, input logic [2:0] f3);
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [7:0]  b3;
    logic [31:0] val;
    b0 = ref_mem[a];
    b1 = ref_mem[a + 10'd1];
    b2 = ref_mem[a + 10'd2];
    b3 = ref_mem[a + 10'd3];
    case (f3)
      3'd0:    val = {{24{b0[7]}}, b0};
      3'd1:    val = {{16{b1[7]}}, b1, b0};
      3'd2:    val = {b3, b2, b1, b0};
      3'd4:    val = {24'd0, b0};
      default: val = {16'd0, b1, b0};
    endcase
    return val;
  endfunction

  task automatic add_test(input string name, input test_entry_t e);
    tests.push_back(e);
    names.push_back(name);
  endtask

  task automatic dmem_store(input string name, input logic [2:0] f3, input logic [9:0] a,
                            input logic [31:0] data, input priv_mode_t priv);
    test_entry_t e;
    e = make_req(1'b1, f3, DATA_MEM_START + {22'd0, a}, data, priv);
    ref_mem[a] = data[7:0];
    if (f3 != 3'd0) begin
      ref_mem[a + 10'd1] = data[15:8];
    end
    if (f3 == 3'd2) begin
      ref_mem[a + 10'd2] = data[23:16];
      ref_mem[a + 10'd3] = data[31:24];
    end
    add_test(name, e);
  endtask

  task automatic load_expect(input string name, input logic [31:0] addr, input logic [2:0] f3,
                             input priv_mode_t priv, input logic [31:0] value);
    test_entry_t e;
    e = make_req(1'b0, f3, addr, 32'd0, priv);
    e.chk_rdata = 1'b1;
    e.exp_rdata = value;
    add_test(name, e);
  endtask

  task automatic dmem_load(input string name, input logic [2:0] f3, input logic [9:0] a,
                           input priv_mode_t priv);
    load_expect(name, DATA_MEM_START + {22'd0, a}, f3, priv, ref_load(a, f3));
  endtask

  // A trapping request returns rdata zero
  task automatic expect_trap(input string name, input logic st, input logic [2:0] f3,
                             input logic [31:0] addr, input priv_mode_t priv,
                             input trap_cause_t cause);
    test_entry_t e;
    e = make_req(st, f3, addr, 32'hDEAD_BEEF, priv);
    e.chk_rdata = 1'b1;
    e.exp_rdata = 32'd0;
    e.exp_cause = cause;
    add_test(name, e);
  endtask

  task automatic build_table;
    test_entry_t e;
    int          r;
    int          word;
    logic [2:0]  st_f3;
    logic [2:0]  ld_f3;
    logic [9:0]  lane;
    cur_irq = 1'b0;
    dmem_store("sw base", 3'd2, 10'h40, 32'h8765_4321, PRIV_M);
    dmem_store("sb offset 1", 3'd0, 10'h41, 32'hFFFF_FFA9, PRIV_M);
    dmem_store("sh offset 2", 3'd1, 10'h42, 32'h1234_C0DE, PRIV_M);
    dmem_store("sb offset 3", 3'd0, 10'h43, 32'h0000_009B, PRIV_M);
    dmem_load("lb offset 1", 3'd0, 10'h41, PRIV_M);
    dmem_load("lbu offset 1", 3'd4, 10'h41, PRIV_M);
    dmem_load("lb offset 3", 3'd0, 10'h43, PRIV_M);
    dmem_load("lbu offset 0", 3'd4, 10'h40, PRIV_M);
    dmem_load("lh offset 2", 3'd1, 10'h42, PRIV_M);
    dmem_load("lhu offset 2", 3'd5, 10'h42, PRIV_M);
    dmem_load("lh offset 0", 3'd1, 10'h40, PRIV_M);
    dmem_load("lw merged", 3'd2, 10'h40, PRIV_M);
    dmem_store("sw second", 3'd2, 10'h44, 32'h7FFF_0102, PRIV_M);
    dmem_load("lh positive", 3'd1, 10'h44, PRIV_M);
    dmem_load("lb all ones", 3'd0, 10'h46, PRIV_M);
    expect_trap("lh misaligned", 1'b0, 3'd1, DATA_MEM_START + 32'h41, PRIV_M,
                CAUSE_LOAD_MISALIGNED);
    expect_trap("lw misaligned", 1'b0, 3'd2, DATA_MEM_START + 32'h42, PRIV_M,
                CAUSE_LOAD_MISALIGNED);
    expect_trap("lhu misaligned", 1'b0, 3'd5, DATA_MEM_START + 32'h43, PRIV_M,
                CAUSE_LOAD_MISALIGNED);
    expect_trap("sh misaligned", 1'b1, 3'd1, DATA_MEM_START + 32'h45, PRIV_M,
                CAUSE_STORE_MISALIGNED);
    expect_trap("sw misaligned", 1'b1, 3'd2, DATA_MEM_START + 32'h46, PRIV_M,
                CAUSE_STORE_MISALIGNED);
    dmem_load("lw after trap", 3'd2, 10'h44, PRIV_M);
    expect_trap("misaligned over fault", 1'b0, 3'd2, CLINT_MEM_START + 32'h2, PRIV_U,
                CAUSE_LOAD_MISALIGNED);
    expect_trap("user store uart", 1'b1, 3'd2, UART_MEM_START, PRIV_U, CAUSE_STORE_FAULT);
    expect_trap("machine store imem", 1'b1, 3'd2, 32'h0000_0100, PRIV_M, CAUSE_STORE_FAULT);
    expect_trap("unmapped store", 1'b1, 3'd0, 32'h2000_0000, PRIV_M, CAUSE_STORE_FAULT);
    expect_trap("user load clint", 1'b0, 3'd2, CLINT_MEM_START, PRIV_U, CAUSE_LOAD_FAULT);
    expect_trap("unmapped load", 1'b0, 3'd2, 32'h4000_0000, PRIV_M, CAUSE_LOAD_FAULT);
    expect_trap("user load uart", 1'b0, 3'd2, UART_MEM_START + 32'h4, PRIV_U,
                CAUSE_LOAD_FAULT);
    load_expect("machine load imem", 32'h0000_0120, 3'd2, PRIV_M, 32'h0000_0120 ^ IMEM_XOR);
    load_expect("user load imem", 32'h0000_0244, 3'd2, PRIV_U, 32'h0000_0244 ^ IMEM_XOR);
    dmem_store("user store dmem", 3'd2, 10'h48, 32'h0BAD_F00D, PRIV_U);
    dmem_load("user load dmem", 3'd2, 10'h48, PRIV_U);
    expect_trap("illegal store f3 3", 1'b1, 3'd3, DATA_MEM_START + 32'h40, PRIV_M,
                CAUSE_ILLEGAL);
    expect_trap("illegal store f3 5", 1'b1, 3'd5, DATA_MEM_START + 32'h44, PRIV_M,
                CAUSE_ILLEGAL);
    expect_trap("illegal load f3 3", 1'b0, 3'd3, DATA_MEM_START + 32'h40, PRIV_M,
                CAUSE_ILLEGAL);
    expect_trap("illegal load f3 6", 1'b0, 3'd6, DATA_MEM_START + 32'h40, PRIV_M,
                CAUSE_ILLEGAL);
    expect_trap("illegal unmapped", 1'b0, 3'd7, 32'h4000_0001, PRIV_U, CAUSE_ILLEGAL);
    dmem_load("lw after illegal 0", 3'd2, 10'h40, PRIV_M);
    dmem_load("lw after illegal 1", 3'd2, 10'h44, PRIV_M);
    e = make_req(1'b1, 3'd0, UART_MEM_START, 32'hDEAD_BE5A, PRIV_M);
    e.exp_tx_valid = 1'b1;
    e.exp_tx_data  = 8'h5A;
    add_test("uart tx byte", e);
    dmem_load("uart tx pulse ends", 3'd2, 10'h48, PRIV_M);
    e = '0;
    e.rx_valid = 1'b1;
    e.rx_data  = 8'hC3;
    e.exp_irq  = cur_irq;
    add_test("uart rx strobe", e);
    load_expect("uart rx full", UART_MEM_START + 32'h4, 3'd2, PRIV_M, 32'h0000_01C3);
    load_expect("uart rx cleared", UART_MEM_START + 32'h4, 3'd2, PRIV_M, 32'h0000_00C3);
    for (int w = 0; w < 8; w++) begin
      dmem_store("random sw init", 3'd2, 10'(32'h100 + 4 * w), $random(seed), PRIV_M);
    end
    for (int n = 0; n < 16; n++) begin
      r     = $unsigned($random(seed)) % 3;
      st_f3 = 3'(r);
      word  = $unsigned($random(seed)) % 8;
      r     = $unsigned($random(seed)) % 4;
      lane  = 10'(r & (4 - (1 << st_f3[1:0])));  // Keep the store naturally aligned
      dmem_store("random store", st_f3, 10'(32'h100 + 4 * word) + lane, $random(seed), PRIV_M);
      r     = $unsigned($random(seed)) % 5;
      ld_f3 = (r < 3) ? 3'(r) : 3'(r + 1);
      r     = $unsigned($random(seed)) % 4;
      lane  = 10'(r & (4 - (1 << ld_f3[1:0])));
      dmem_load("random load", ld_f3, 10'(32'h100 + 4 * word) + lane, PRIV_M);
    end
    add_test("mtimecmp lo ones", make_req(1'b1, 3'd2, CLINT_MEM_START + 32'h8, '1, PRIV_M));
    add_test("mtimecmp hi ones", make_req(1'b1, 3'd2, CLINT_MEM_START + 32'hC, '1, PRIV_M));
    expect_trap("user load mtimecmp", 1'b0, 3'd2, CLINT_MEM_START + 32'h8, PRIV_U,
                CAUSE_LOAD_FAULT);
    add_test("mtimecmp lo zero", make_req(1'b1, 3'd2, CLINT_MEM_START + 32'h8, '0, PRIV_M));
    load_expect("mtimecmp lo readback", CLINT_MEM_START + 32'h8, 3'd2, PRIV_M, 32'h0000_0000);
    load_expect("mtimecmp hi readback", CLINT_MEM_START + 32'hC, 3'd2, PRIV_M, 32'hFFFF_FFFF);
    add_test("mtimecmp hi zero", make_req(1'b1, 3'd2, CLINT_MEM_START + 32'hC, '0, PRIV_M));
    cur_irq = 1'b1;  // Registered compare rises one cycle after the last write
    dmem_load("timer irq raised", 3'd2, 10'h40, PRIV_M);
    expect_trap("user load mtime", 1'b0, 3'd2, CLINT_MEM_START, PRIV_U, CAUSE_LOAD_FAULT);
  endtask

  task automatic check_entry(input int idx);
    test_entry_t e;
    int          bad;
    e   = tests[idx];
    bad = 0;
    if (resp.valid !== e.exp_valid) begin
      $display("Fail at %0t: %s valid %b, expected %b", $time, names[idx], resp.valid,
               e.exp_valid);
      bad++;
    end
    if (e.exp_valid && resp.trap !== (e.exp_cause != CAUSE_NONE)) begin
      $display("Fail at %0t: %s trap %b, expected %b", $time, names[idx], resp.trap,
               e.exp_cause != CAUSE_NONE);
      bad++;
    end
    if (e.exp_valid && resp.cause !== e.exp_cause) begin
      $display("Fail at %0t: %s cause %0d, expected %0d", $time, names[idx], resp.cause,
               e.exp_cause);
      bad++;
    end
    if (e.chk_rdata && resp.rdata !== e.exp_rdata) begin
      $display("Fail at %0t: %s rdata %h, expected %h", $time, names[idx], resp.rdata,
               e.exp_rdata);
      bad++;
    end
    if (tx_valid !== e.exp_tx_valid) begin
      $display("Fail at %0t: %s tx valid %b, expected %b", $time, names[idx], tx_valid,
               e.exp_tx_valid);
      bad++;
    end
    if (e.exp_tx_valid && tx_data !== e.exp_tx_data) begin
      $display("Fail at %0t: %s tx data %h, expected %h", $time, names[idx], tx_data,
               e.exp_tx_data);
      bad++;
    end
    if (timer_irq !== e.exp_irq) begin
      $display("Fail at %0t: %s timer irq %b, expected %b", $time, names[idx], timer_irq,
               e.exp_irq);
      bad++;
    end
    if (bad == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("Test %0d %s: %s", idx, names[idx], (bad == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    req      = '0;
    rx_valid = 1'b0;
    rx_data  = 8'd0;
    rst_n    = 1'b0;
    build_table();
    max_cycles = tests.size() * 4 + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    if (resp.valid !== 1'b0 || tx_valid !== 1'b0 || timer_irq !== 1'b0) begin
      $display("Fail at %0t: outputs not low after reset", $time);
      failed++;
    end else begin
      passed++;
    end
    $display("Test reset state: %s", (failed == 0) ? "ok" : "mismatch");
    rst_n = 1'b1;
    for (int i = 0; i < tests.size(); i++) begin
      req      = tests[i].req;
      rx_valid = tests[i].rx_valid;
      rx_data  = tests[i].rx_data;
      @(negedge clk);
      check_entry(i);
    end
    req      = '0;
    rx_valid = 1'b0;
    $display("Checks run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu.sv
design/data_mem.sv
design/clint.sv
design/uart_regs.sv
design/lsu_result.sv
design/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_mem_subsys -f list.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
